//--- rtl/cache_bridge_pkg.sv
package cache_bridge_pkg;

    // basic widths
    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] word_t;    // one data beat
    typedef logic [3:0]  axi_id_t;

    // burst shape, incrementing, one word per beat
    localparam int LINE_WORDS = 4;

    // word 0 in the low bits
    typedef word_t [LINE_WORDS-1:0] cache_line_t;

    // default AXI IDs per requester
    localparam axi_id_t ICACHE_ID = 4'd0;
    localparam axi_id_t DCACHE_ID = 4'd1;

    // read address channel payload
    typedef struct packed {
        axi_id_t id;
        addr_t   addr;
    } ar_req_t;

    // read data channel payload
    typedef struct packed {
        axi_id_t id;
        word_t   data;
        logic    last;
    } r_beat_t;

    // cache side line read request
    typedef struct packed {
        logic  req;
        addr_t addr;
    } rd_req_t;

endpackage

//--- rtl/line_read_engine.sv
`timescale 1ns/10ps

module line_read_engine #(
    parameter cache_bridge_pkg::axi_id_t AXI_ID = cache_bridge_pkg::ICACHE_ID
) (
    input  logic                          clk,
    input  logic                          reset,
    input  cache_bridge_pkg::rd_req_t     rd,
    output logic                          rd_rdy,
    output logic                          ret_valid,
    output cache_bridge_pkg::cache_line_t ret_data,
    output cache_bridge_pkg::ar_req_t     ar_out,
    output logic                          ar_valid,
    input  logic                          ar_ready,
    input  logic                          beat_valid,
    input  cache_bridge_pkg::r_beat_t     beat,
    output logic                          rready
);

    import cache_bridge_pkg::*;

    // bit 2 marks the beat states, bits 1:0 give the word index
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_ADDR  = 3'd1,
        S_BEAT0 = 3'd4,
        S_BEAT1 = 3'd5,
        S_BEAT2 = 3'd6,
        S_BEAT3 = 3'd7
    } rd_state_t;

    rd_state_t   state;
    rd_state_t   state_next;
    addr_t       addr_q;
    cache_line_t line_q;
    logic        accept;
    logic        beat_take;

    assign accept    = rd.req && rd_rdy;
    assign beat_take = beat_valid && rready;

    assign rd_rdy      = (state == S_IDLE);
    assign ar_valid    = (state == S_ADDR);
    assign rready      = state[2];
    assign ar_out.id   = AXI_ID;
    assign ar_out.addr = addr_q;
    assign ret_data    = line_q;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:  if (accept) state_next = S_ADDR;
            S_ADDR:  if (ar_valid && ar_ready) state_next = S_BEAT0;
            S_BEAT0: if (beat_take) state_next = S_BEAT1;
            S_BEAT1: if (beat_take) state_next = S_BEAT2;
            S_BEAT2: if (beat_take) state_next = S_BEAT3;
            S_BEAT3: if (beat_take && beat.last) state_next = S_IDLE;
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            ret_valid <= 1'b0;
        end else begin
            state     <= state_next;
            // one cycle pulse, same edge as the last word lands
            ret_valid <= (state == S_BEAT3) && (state_next == S_IDLE);
        end
    end

    // address held stable for the whole AR phase
    always_ff @(posedge clk) begin
        if (accept)
            addr_q <= rd.addr;
    end

    always_ff @(posedge clk) begin
        if (beat_take)
            line_q[state[1:0]] <= beat.data;    // word k from beat k
    end

endmodule

//--- rtl/line_write_engine.sv
`timescale 1ns/10ps

module line_write_engine (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_req,
    input  cache_bridge_pkg::addr_t       wr_addr,
    input  cache_bridge_pkg::cache_line_t wr_data,
    output logic                          wr_rdy,
    output cache_bridge_pkg::addr_t       awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output cache_bridge_pkg::word_t       wdata,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid
);

    import cache_bridge_pkg::*;

    localparam int CNT_W = $clog2(LINE_WORDS);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(LINE_WORDS - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } wr_state_t;

    wr_state_t        state;
    wr_state_t        state_next;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_next;
    addr_t            addr_q;
    cache_line_t      line_q;
    logic             accept;
    logic             w_take;
    logic             bready;

    assign bready = 1'b1;   // response always taken
    assign accept = wr_req && wr_rdy;
    assign w_take = wvalid && wready;

    assign wr_rdy  = (state == S_IDLE);
    assign awvalid = (state == S_ADDR);
    assign awaddr  = addr_q;
    assign wvalid  = (state == S_DATA);
    assign wlast   = wvalid && (cnt == LAST_BEAT);  // fourth beat only

    always_comb begin
        state_next = state;
        cnt_next   = cnt;
        case (state)
            S_IDLE: begin
                if (accept)
                    state_next = S_ADDR;
            end
            S_ADDR: begin
                if (awvalid && awready) begin
                    state_next = S_DATA;
                    cnt_next   = '0;
                end
            end
            S_DATA: begin
                if (w_take) begin
                    if (cnt == LAST_BEAT)
                        state_next = S_RESP;
                    else
                        cnt_next = cnt + 1'b1;
                end
            end
            S_RESP: begin
                if (bvalid && bready)
                    state_next = S_IDLE;
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_next;
            cnt   <= cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= wr_addr;
            line_q <= wr_data;
        end
    end

    // next word loaded ahead, so wdata is stable while wvalid waits
    always_ff @(posedge clk) begin
        if (state_next == S_DATA)
            wdata <= line_q[cnt_next];
    end

endmodule

//--- rtl/read_port_arbiter.sv
`timescale 1ns/10ps

module read_port_arbiter #(
    parameter cache_bridge_pkg::axi_id_t ICACHE_ID = cache_bridge_pkg::ICACHE_ID,
    parameter cache_bridge_pkg::axi_id_t DCACHE_ID = cache_bridge_pkg::DCACHE_ID
) (
    input  logic                      clk,
    input  logic                      reset,
    // engine side address requests
    input  cache_bridge_pkg::ar_req_t d_ar,
    input  cache_bridge_pkg::ar_req_t i_ar,
    input  logic                      d_ar_valid,
    input  logic                      i_ar_valid,
    output logic                      d_ar_ready,
    output logic                      i_ar_ready,
    // shared AXI read address channel
    output cache_bridge_pkg::ar_req_t ar,
    output logic                      arvalid,
    input  logic                      arready,
    // shared AXI read data channel
    input  cache_bridge_pkg::r_beat_t r,
    input  logic                      rvalid,
    output logic                      rready,
    // engine side read data
    output logic                      d_beat_valid,
    output logic                      i_beat_valid,
    output cache_bridge_pkg::r_beat_t beat,
    input  logic                      d_rready,
    input  logic                      i_rready
);

    import cache_bridge_pkg::*;

    logic lock_q;       // grant held while arvalid waits
    logic lock_sel_q;   // 1 = dcache holds the lock
    logic sel_d;
    logic r_is_d;
    logic r_is_i;

    // dcache first unless the port is locked
    assign sel_d = lock_q ? lock_sel_q : d_ar_valid;

    assign ar         = sel_d ? d_ar : i_ar;
    assign arvalid    = sel_d ? d_ar_valid : i_ar_valid;
    assign d_ar_ready = sel_d && arready;
    assign i_ar_ready = !sel_d && arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_q     <= 1'b0;
            lock_sel_q <= 1'b0;
        end else begin
            lock_q     <= arvalid && !arready;
            lock_sel_q <= sel_d;
        end
    end

    // read data steered by ID
    assign r_is_d = (r.id == DCACHE_ID);
    assign r_is_i = (r.id == ICACHE_ID);

    assign beat         = r;
    assign d_beat_valid = rvalid && r_is_d;
    assign i_beat_valid = rvalid && r_is_i;

    always_comb begin
        if (r_is_d)
            rready = d_rready;
        else if (r_is_i)
            rready = i_rready;
        else
            rready = 1'b0;  // unknown id, never taken
    end

endmodule

//--- rtl/cache_axi_bridge.sv
`timescale 1ns/10ps

module cache_axi_bridge #(
    parameter cache_bridge_pkg::axi_id_t ICACHE_ID = cache_bridge_pkg::ICACHE_ID,
    parameter cache_bridge_pkg::axi_id_t DCACHE_ID = cache_bridge_pkg::DCACHE_ID
) (
    input  logic                          clk,
    input  logic                          reset,
    // instruction cache refill
    input  cache_bridge_pkg::rd_req_t     icache_rd,
    output logic                          icache_rd_rdy,
    output logic                          icache_ret_valid,
    output cache_bridge_pkg::cache_line_t icache_ret_data,
    // data cache refill
    input  cache_bridge_pkg::rd_req_t     dcache_rd,
    output logic                          dcache_rd_rdy,
    output logic                          dcache_ret_valid,
    output cache_bridge_pkg::cache_line_t dcache_ret_data,
    // data cache write-back
    input  logic                          dcache_wr_req,
    input  cache_bridge_pkg::addr_t       dcache_wr_addr,
    input  cache_bridge_pkg::cache_line_t dcache_wr_data,
    output logic                          dcache_wr_rdy,
    // AXI read
    output cache_bridge_pkg::ar_req_t     ar,
    output logic                          arvalid,
    input  logic                          arready,
    input  cache_bridge_pkg::r_beat_t     r,
    input  logic                          rvalid,
    output logic                          rready,
    // AXI write
    output cache_bridge_pkg::addr_t       awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output cache_bridge_pkg::word_t       wdata,
    output logic                          wlast,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid
);

    import cache_bridge_pkg::*;

    ar_req_t i_ar;
    ar_req_t d_ar;
    logic    i_ar_valid;
    logic    d_ar_valid;
    logic    i_ar_ready;
    logic    d_ar_ready;
    logic    i_beat_valid;
    logic    d_beat_valid;
    r_beat_t beat;          // shared, qualified per engine
    logic    i_rready;
    logic    d_rready;

    line_read_engine #(.AXI_ID(ICACHE_ID)) u_iread (
        .clk        (clk),
        .reset      (reset),
        .rd         (icache_rd),
        .rd_rdy     (icache_rd_rdy),
        .ret_valid  (icache_ret_valid),
        .ret_data   (icache_ret_data),
        .ar_out     (i_ar),
        .ar_valid   (i_ar_valid),
        .ar_ready   (i_ar_ready),
        .beat_valid (i_beat_valid),
        .beat       (beat),
        .rready     (i_rready)
    );

    line_read_engine #(.AXI_ID(DCACHE_ID)) u_dread (
        .clk        (clk),
        .reset      (reset),
        .rd         (dcache_rd),
        .rd_rdy     (dcache_rd_rdy),
        .ret_valid  (dcache_ret_valid),
        .ret_data   (dcache_ret_data),
        .ar_out     (d_ar),
        .ar_valid   (d_ar_valid),
        .ar_ready   (d_ar_ready),
        .beat_valid (d_beat_valid),
        .beat       (beat),
        .rready     (d_rready)
    );

    read_port_arbiter #(
        .ICACHE_ID (ICACHE_ID),
        .DCACHE_ID (DCACHE_ID)
    ) u_rarb (
        .clk          (clk),
        .reset        (reset),
        .d_ar         (d_ar),
        .i_ar         (i_ar),
        .d_ar_valid   (d_ar_valid),
        .i_ar_valid   (i_ar_valid),
        .d_ar_ready   (d_ar_ready),
        .i_ar_ready   (i_ar_ready),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .d_beat_valid (d_beat_valid),
        .i_beat_valid (i_beat_valid),
        .beat         (beat),
        .d_rready     (d_rready),
        .i_rready     (i_rready)
    );

    // write path owns aw, w and b alone
    line_write_engine u_write (
        .clk     (clk),
        .reset   (reset),
        .wr_req  (dcache_wr_req),
        .wr_addr (dcache_wr_addr),
        .wr_data (dcache_wr_data),
        .wr_rdy  (dcache_wr_rdy),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid)
    );

endmodule

//--- sim/bridge_chk.sv
`timescale 1ns/10ps

module bridge_chk (
    input logic                      clk,
    input logic                      reset,
    input cache_bridge_pkg::ar_req_t ar,
    input logic                      arvalid,
    input logic                      arready,
    input logic                      rvalid,
    input logic                      d_beat_valid,
    input logic                      i_beat_valid,
    input logic                      sel_d
);

    int assert_errors = 0;

    // payload frozen while the slave stalls
    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("arvalid dropped or ar changed before arready");
            assert_errors++;
        end

    // every offered beat goes to exactly one engine
    beat_onehot: assert property (@(posedge clk) disable iff (reset)
        rvalid |-> (d_beat_valid ^ i_beat_valid))
        else begin
            $error("read beat not steered to exactly one engine");
            assert_errors++;
        end

    // stalled request keeps its grant next cycle
    grant_locked: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> sel_d == $past(sel_d))
        else begin
            $error("read grant switched while the lock was held");
            assert_errors++;
        end

endmodule

bind read_port_arbiter bridge_chk chk0 (
    .clk          (clk),
    .reset        (reset),
    .ar           (ar),
    .arvalid      (arvalid),
    .arready      (arready),
    .rvalid       (rvalid),
    .d_beat_valid (d_beat_valid),
    .i_beat_valid (i_beat_valid),
    .sel_d        (sel_d)
);

//--- sim/bridge_monitor.sv
`timescale 1ns/10ps

module bridge_monitor #(
    parameter cache_bridge_pkg::axi_id_t DCACHE_ID = cache_bridge_pkg::DCACHE_ID
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [8*16-1:0]               test_name,
    input  cache_bridge_pkg::rd_req_t     icache_rd,
    input  logic                          icache_rd_rdy,
    input  logic                          icache_ret_valid,
    input  cache_bridge_pkg::cache_line_t icache_ret_data,
    input  cache_bridge_pkg::rd_req_t     dcache_rd,
    input  logic                          dcache_rd_rdy,
    input  logic                          dcache_ret_valid,
    input  cache_bridge_pkg::cache_line_t dcache_ret_data,
    input  logic                          dcache_wr_req,
    input  cache_bridge_pkg::addr_t       dcache_wr_addr,
    input  cache_bridge_pkg::cache_line_t dcache_wr_data,
    input  logic                          dcache_wr_rdy,
    input  cache_bridge_pkg::ar_req_t     ar,
    input  logic                          arvalid,
    input  logic                          rvalid,
    input  logic                          rready,
    input  cache_bridge_pkg::addr_t       awaddr,
    input  logic                          awvalid,
    input  logic                          awready,
    input  cache_bridge_pkg::word_t       wdata,
    input  logic                          wlast,
    input  logic                          wvalid,
    input  logic                          wready,
    input  logic                          bvalid,
    output int                            value_errors,
    output int                            other_errors
);

    import cache_bridge_pkg::*;

    addr_t       i_addr;
    addr_t       d_addr;
    addr_t       w_addr;
    cache_line_t w_line;
    logic        i_busy;
    logic        d_busy;
    logic        w_busy;
    logic        w_resp;        // b seen, wr_rdy due now
    logic        both_start;
    logic        reset_q;
    int          w_beats;

    initial begin
        value_errors = 0;
        other_errors = 0;
    end

    task automatic compare_value(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[FAIL] %0s %0s: expected %h, actual %h", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("error in %0s: %0s", test_name, msg);
        other_errors++;
    endtask

    // word k of the line at A reads back as ~(A + 4k)
    task automatic check_line(input string who, input addr_t a, input cache_line_t got);
        for (int k = 0; k < LINE_WORDS; k++)
            compare_value($sformatf("%0s word %0d", who, k), ~(a + addr_t'(4 * k)), got[k]);
    endtask

    always @(posedge clk) begin
        reset_q <= reset;
        if (reset) begin
            i_busy     <= 1'b0;
            d_busy     <= 1'b0;
            w_busy     <= 1'b0;
            w_resp     <= 1'b0;
            both_start <= 1'b0;
            w_beats    <= 0;
        end else begin
            if (reset_q) begin      // first cycle out of reset
                if (!(icache_rd_rdy && dcache_rd_rdy && dcache_wr_rdy))
                    report_problem("a rdy output is low after reset");
                if (icache_ret_valid || dcache_ret_valid || arvalid || awvalid || wvalid)
                    report_problem("a valid output is high after reset");
            end
            if (icache_rd.req && icache_rd_rdy) begin
                i_busy <= 1'b1;
                i_addr <= icache_rd.addr;
            end
            if (dcache_rd.req && dcache_rd_rdy) begin
                d_busy <= 1'b1;
                d_addr <= dcache_rd.addr;
            end
            if (icache_rd.req && icache_rd_rdy && dcache_rd.req && dcache_rd_rdy)
                both_start <= 1'b1;
            if (both_start && arvalid) begin
                compare_value("first ar id", word_t'(DCACHE_ID), word_t'(ar.id));
                compare_value("first ar addr", d_addr, ar.addr);
                both_start <= 1'b0;
            end
            // beats only follow an accepted AR, so the owner is waiting for them
            if (rvalid && !rready)
                report_problem("rready low while a read beat is offered");
            // a pulse with nothing in flight means ret_valid ran long
            if (icache_ret_valid) begin
                if (!i_busy)
                    report_problem("icache ret_valid without a request in flight");
                else
                    check_line("icache", i_addr, icache_ret_data);
                if (!icache_rd_rdy)
                    report_problem("icache rd_rdy low in the ret_valid cycle");
                i_busy <= 1'b0;
            end
            if (dcache_ret_valid) begin
                if (!d_busy)
                    report_problem("dcache ret_valid without a request in flight");
                else
                    check_line("dcache", d_addr, dcache_ret_data);
                if (!dcache_rd_rdy)
                    report_problem("dcache rd_rdy low in the ret_valid cycle");
                d_busy <= 1'b0;
            end
            if (dcache_wr_req && dcache_wr_rdy) begin
                w_busy  <= 1'b1;
                w_addr  <= dcache_wr_addr;
                w_line  <= dcache_wr_data;
                w_beats <= 0;
            end
            if (w_busy && dcache_wr_rdy)
                report_problem("dcache_wr_rdy high before the write response");
            if (awvalid && awready)
                compare_value("awaddr", w_addr, awaddr);
            if (wvalid && wready) begin
                if (w_beats >= LINE_WORDS) begin
                    report_problem("more than four write beats");
                end else begin
                    compare_value($sformatf("wdata beat %0d", w_beats), w_line[w_beats], wdata);
                    compare_value($sformatf("wlast beat %0d", w_beats),
                                  word_t'(w_beats == LINE_WORDS - 1), word_t'(wlast));
                end
                w_beats <= w_beats + 1;
            end
            if (bvalid && w_busy) begin
                if (w_beats != LINE_WORDS)
                    report_problem("write response before all four beats");
                w_busy <= 1'b0;
                w_resp <= 1'b1;
            end
            if (w_resp) begin
                if (!dcache_wr_rdy)
                    report_problem("dcache_wr_rdy did not return after bvalid");
                w_resp <= 1'b0;
            end
        end
    end

endmodule

//--- sim/tb_cache_axi_bridge.sv
`timescale 1ns/10ps

module tb_cache_axi_bridge;

    import cache_bridge_pkg::*;

    localparam int N_TESTS        = 8;
    localparam int TIMEOUT_CYCLES = N_TESTS * 60;

    typedef enum logic [2:0] {
        OP_IREAD,
        OP_DREAD,
        OP_WRITE,
        OP_BOTH,        // icache and dcache reads in one cycle
        OP_WRITE_READ,  // write-back with a dcache read beside it
        OP_I_THEN_D     // dcache read one cycle behind the icache read
    } op_t;

    typedef struct packed {
        logic [8*16-1:0] name;
        op_t             op;
        addr_t           addr;
        cache_line_t     line;
    } stim_t;

    logic        clk = 1'b0;
    logic        reset;
    rd_req_t     icache_rd;
    rd_req_t     dcache_rd;
    logic        dcache_wr_req;
    addr_t       dcache_wr_addr;
    cache_line_t dcache_wr_data;
    logic        icache_rd_rdy;
    logic        icache_ret_valid;
    cache_line_t icache_ret_data;
    logic        dcache_rd_rdy;
    logic        dcache_ret_valid;
    cache_line_t dcache_ret_data;
    logic        dcache_wr_rdy;
    ar_req_t     ar;
    logic        arvalid;
    logic        arready = 1'b0;
    r_beat_t     r = '0;
    logic        rvalid = 1'b0;
    logic        rready;
    addr_t       awaddr;
    logic        awvalid;
    logic        awready = 1'b0;
    word_t       wdata;
    logic        wlast;
    logic        wvalid;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;

    logic [8*16-1:0] cur_name;
    int              value_errors;
    int              other_errors;
    stim_t           stim [N_TESTS];
    ar_req_t         ar_q [$];      // accepted AR requests, answered in order
    int              rd_beat;
    logic            b_owed;
    int              seed = 32'h375b68da;
    int              cycle_count = 0;

    always #50 clk = ~clk;

    cache_axi_bridge dut0 (.*);

    bridge_monitor mon0 (
        .test_name (cur_name),
        .*
    );

    function automatic cache_line_t make_line(input word_t base);
        cache_line_t l;
        for (int k = 0; k < LINE_WORDS; k++)
            l[k] = base + word_t'(k);
        return l;
    endfunction

    function automatic void fill_table();
        stim[0] = '{"iread_basic", OP_IREAD, 32'h0000_1000, '0};
        stim[1] = '{"dread_stall", OP_DREAD, 32'h0000_2040, '0};
        stim[2] = '{"both_reads", OP_BOTH, 32'h0000_3000, '0};
        stim[3] = '{"dwrite_line", OP_WRITE, 32'h0000_4000, make_line(32'ha5a5_0000)};
        stim[4] = '{"write_and_read", OP_WRITE_READ, 32'h0000_5010, make_line(32'h3c3c_1000)};
        stim[5] = '{"iread_high", OP_IREAD, 32'hffff_ff00, '0};
        stim[6] = '{"both_again", OP_BOTH, 32'h8000_0020, '0};
        stim[7] = '{"late_dread", OP_I_THEN_D, 32'h0000_6000, '0};
    endfunction

    task automatic run_entry(input stim_t e);
        logic i_on;
        logic d_on;
        logic d_late;
        logic w_on;
        logic i_done;
        logic d_done;
        logic w_done;
        i_on   = (e.op == OP_IREAD) || (e.op == OP_BOTH) || (e.op == OP_I_THEN_D);
        d_on   = (e.op == OP_DREAD) || (e.op == OP_BOTH) || (e.op == OP_WRITE_READ)
                 || (e.op == OP_I_THEN_D);
        d_late = (e.op == OP_I_THEN_D);
        w_on   = (e.op == OP_WRITE) || (e.op == OP_WRITE_READ);
        @(posedge clk);
        cur_name       <= e.name;
        icache_rd.req  <= i_on;
        icache_rd.addr <= e.addr;
        dcache_rd.req  <= d_on && !d_late;
        dcache_rd.addr <= (e.op == OP_DREAD) ? e.addr : e.addr + 32'h100;  // own line
        dcache_wr_req  <= w_on;
        dcache_wr_addr <= e.addr;
        dcache_wr_data <= e.line;
        @(posedge clk);     // all rdys are high between entries, so this edge accepts
        icache_rd.req <= 1'b0;
        dcache_rd.req <= d_late;    // arrives while the icache AR still waits
        dcache_wr_req <= 1'b0;
        if (d_late) begin
            @(posedge clk);
            dcache_rd.req <= 1'b0;
        end
        i_done = !i_on;
        d_done = !d_on;
        w_done = !w_on;
        while (!(i_done && d_done && w_done)) begin
            @(posedge clk);
            i_done = i_done || icache_ret_valid;
            d_done = d_done || dcache_ret_valid;
            w_done = w_done || dcache_wr_rdy;
        end
    endtask

    // AXI slave, in-order reads, random stalls on every ready and valid
    always @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            ar_q.delete();
            rd_beat = 0;
            b_owed  = 1'b0;
        end else begin
            if (arvalid && arready)
                ar_q.push_back(ar);
            if (rvalid && rready) begin
                if (rd_beat == LINE_WORDS - 1) begin
                    rd_beat = 0;
                    void'(ar_q.pop_front());
                end else begin
                    rd_beat = rd_beat + 1;
                end
            end
            if (!rvalid || rready) begin    // rvalid drops only after a handshake
                if (ar_q.size() > 0 && ($random(seed) & 3) != 0) begin
                    rvalid <= 1'b1;
                    r.id   <= ar_q[0].id;
                    r.data <= ~(ar_q[0].addr + addr_t'(4 * rd_beat));
                    r.last <= (rd_beat == LINE_WORDS - 1);
                end else begin
                    rvalid <= 1'b0;
                end
            end
            // never ready in the first cycle of a new arvalid
            arready <= (($random(seed) & 3) != 0) && arvalid;
            awready <= ($random(seed) & 3) != 0;
            wready  <= ($random(seed) & 3) != 0;
            if (wvalid && wready && wlast)
                b_owed = 1'b1;
            if (bvalid) begin
                bvalid <= 1'b0;     // bready is always high
            end else if (b_owed && ($random(seed) & 1)) begin
                bvalid <= 1'b1;
                b_owed = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int total;
        reset          = 1'b1;
        icache_rd      = '0;
        dcache_rd      = '0;
        dcache_wr_req  = 1'b0;
        dcache_wr_addr = '0;
        dcache_wr_data = '0;
        cur_name       = "reset";
        fill_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < N_TESTS; n++)
            run_entry(stim[n]);
        repeat (4) @(posedge clk);
        total = value_errors + other_errors + dut0.u_rarb.chk0.assert_errors;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, other_errors, dut0.u_rarb.chk0.assert_errors);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- build.f
rtl/cache_bridge_pkg.sv
rtl/line_read_engine.sv
rtl/line_write_engine.sv
rtl/read_port_arbiter.sv
rtl/cache_axi_bridge.sv
sim/bridge_chk.sv
sim/bridge_monitor.sv
sim/tb_cache_axi_bridge.sv
